// File: src/rob_pkg.sv
/*
 * Shared definitions for the commit stage: buffer and register file
 * geometry, vector types and the commit state encoding
 */
package rob_pkg;

    // The reorder buffer holds this many instructions in flight
    localparam int ROB_DEPTH = 16;

    // One tag bit per doubling of the buffer depth
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH);

    // Width of a register value as it travels on the CDB and into the map
    localparam int DATA_WIDTH = 32;

    // Width of a redirect target handed back to fetch
    localparam int ADDR_WIDTH = 32;

    // Architectural register file size and its index width
    localparam int REG_COUNT      = 32;
    localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);

    // A register value
    typedef logic [DATA_WIDTH-1:0] data_t;

    // A redirect target address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Index of one reorder buffer entry, also the tag of its instruction
    typedef logic [TAG_WIDTH-1:0] rob_tag_t;

    // Head and tail pointers carry one extra wrap bit above the index
    // so that full and empty can be told apart
    typedef logic [TAG_WIDTH:0] rob_ptr_t;

    // Index of one architectural register
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Normal in-order retire, or the single cycle that wipes busy marks
    // after a redirect
    typedef enum logic {
        COMMIT = 1'b0,
        FLUSH  = 1'b1
    } commit_state_t;

endpackage

// File: src/ooo_ifs.sv
/*
 * Bundles between the commit stage blocks: CDB broadcast, dispatch
 * port, register map lookup and the retire write
 */

// Results from the execution units, one strobe per completed instruction
interface cdb_if import rob_pkg::*; ();
    logic     en;
    rob_tag_t tag;
    data_t    data;
    logic     redirect;
    addr_t    addr;

    modport source (output en, tag, data, redirect, addr);
    modport sink   (input  en, tag, data, redirect, addr);
endinterface

// In-order enqueue into the tail of the reorder buffer
interface rob_dispatch_if import rob_pkg::*; ();
    logic      en;
    reg_addr_t rdest;
    logic      rdy;
    data_t     data;
    logic      stall;
    rob_tag_t  tag;

    modport source (output en, rdest, rdy, data, input  stall, tag);
    modport sink   (input  en, rdest, rdy, data, output stall, tag);
endinterface

// Combinational read of two source registers from the register map
interface regmap_lookup_if import rob_pkg::*; ();
    reg_addr_t rsrc [2];
    data_t     data [2];
    rob_tag_t  tag  [2];
    logic      busy [2];

    modport requester (output rsrc, input  data, tag, busy);
    modport responder (input  rsrc, output data, tag, busy);
endinterface

// Retiring head entry written into the architectural state
interface retire_wr_if import rob_pkg::*; ();
    logic      en;
    reg_addr_t rdest;
    data_t     data;
    rob_tag_t  tag;

    modport source (output en, rdest, data, tag);
    modport sink   (input  en, rdest, data, tag);
endinterface

// File: src/rob_pointers.sv
/*
 * Head and tail pointers of the reorder buffer with a wrap bit
 * for full and empty detection and a clear on redirect
 */
module rob_pointers import rob_pkg::*; (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     push,
    input  logic     pop,
    input  logic     clear,
    output rob_ptr_t head,
    output rob_ptr_t tail,
    output logic     full,
    output logic     empty
);

    // Difference with only the wrap bit set means the tail lapped the head
    localparam rob_ptr_t WRAP_ONLY = rob_ptr_t'(1) << TAG_WIDTH;

    // Tail moves on every accepted dispatch
    // A clear puts both pointers back to entry zero and wins over a push
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tail <= '0;
        end else if (clear) begin
            tail <= '0;
        end else if (push) begin
            tail <= tail + 1'b1;
        end
    end

    // Head moves on every retire, with the same clear priority
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
        end else if (clear) begin
            head <= '0;
        end else if (pop) begin
            head <= head + 1'b1;
        end
    end

    // Same index on both sides, the wrap bit decides between full and empty
    assign full  = ((head ^ tail) == WRAP_ONLY);
    assign empty = (head == tail);

endmodule

// File: src/commit_ctrl.sv
/*
 * Commit sequencer: stays in normal commit and spends exactly one
 * flush cycle after a redirect retires
 */
module commit_ctrl import rob_pkg::*; (
    input  logic          clk,
    input  logic          n_rst,
    input  logic          redirect,
    output logic          flush,
    output commit_state_t state
);

    commit_state_t next_state;

    // State register
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= COMMIT;
        end else begin
            state <= next_state;
        end
    end

    // Next state logic
    always_comb begin
        next_state = state;
        case (state)
            COMMIT: begin
                // The redirecting entry retires in this cycle and the
                // younger entries are thrown away at the same edge
                if (redirect) begin
                    next_state = FLUSH;
                end
            end
            FLUSH: begin
                // One cycle is enough to wipe every busy mark in the map
                next_state = COMMIT;
            end
            default: begin
                next_state = COMMIT;
            end
        endcase
    end

    // Flush holds dispatch off and clears the register map busy bits
    assign flush = (state == FLUSH);

endmodule

// File: src/reorder_buffer.sv
/*
 * Reorder buffer entry storage with CDB writeback, in-order retire
 * from the head and forwarding of source operands at dispatch
 */
module reorder_buffer import rob_pkg::*; (
    input  logic                      clk,
    input  logic                      n_rst,
    cdb_if.sink                       cdb,
    rob_dispatch_if.sink              disp,
    input  reg_addr_t                 rsrc_a,
    input  reg_addr_t                 rsrc_b,
    input  logic                      flush,
    input  rob_ptr_t                  head,
    input  rob_ptr_t                  tail,
    input  logic                      full,
    input  logic                      empty,
    regmap_lookup_if.requester        lookup,
    retire_wr_if.source               retire,
    output logic                      tag_wr_en,
    output reg_addr_t                 tag_wr_rdest,
    output rob_tag_t                  tag_wr_tag,
    output data_t                     src_data [2],
    output rob_tag_t                  src_tag  [2],
    output logic                      src_rdy  [2],
    output logic                      redirect,
    output addr_t                     redirect_addr,
    output logic                      push,
    output logic                      pop
);

    // Per-entry fields, kept as separate arrays
    logic      entry_rdy      [ROB_DEPTH];
    logic      entry_redirect [ROB_DEPTH];
    addr_t     entry_target   [ROB_DEPTH];
    data_t     entry_data     [ROB_DEPTH];
    reg_addr_t entry_rdest    [ROB_DEPTH];

    rob_tag_t head_idx;
    rob_tag_t tail_idx;
    logic     disp_accept;
    logic     retire_en;

    assign head_idx = head[TAG_WIDTH-1:0];
    assign tail_idx = tail[TAG_WIDTH-1:0];

    // The buffer refuses new work while full or while the map is flushed
    assign disp.stall  = full || flush;
    assign disp.tag    = tail_idx;
    assign disp_accept = disp.en && !disp.stall;
    assign push        = disp_accept;

    // The new destination is claimed in the register map under the tail tag
    assign tag_wr_en    = disp_accept;
    assign tag_wr_rdest = disp.rdest;
    assign tag_wr_tag   = tail_idx;

    // Head retires as soon as its result is in and the buffer holds something
    assign retire_en = entry_rdy[head_idx] && !empty;
    assign pop       = retire_en;

    assign retire.en    = retire_en;
    assign retire.rdest = entry_rdest[head_idx];
    assign retire.data  = entry_data[head_idx];
    assign retire.tag   = head_idx;

    // A retiring branch sends fetch to its target in the same cycle
    assign redirect      = retire_en && entry_redirect[head_idx];
    assign redirect_addr = entry_target[head_idx];

    // Both sources are looked up in the register map in parallel
    assign lookup.rsrc[0] = rsrc_a;
    assign lookup.rsrc[1] = rsrc_b;

    // Source operand priority is the register map value when the register
    // is idle, then a matching CDB broadcast in this cycle, and last the
    // owning entry in the buffer, which may still be waiting
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_tag[i] = lookup.tag[i];
            if (!lookup.busy[i]) begin
                src_data[i] = lookup.data[i];
                src_rdy[i]  = 1'b1;
            end else if (cdb.en && (cdb.tag == lookup.tag[i])) begin
                src_data[i] = cdb.data;
                src_rdy[i]  = 1'b1;
            end else begin
                src_data[i] = entry_data[lookup.tag[i]];
                src_rdy[i]  = entry_rdy[lookup.tag[i]];
            end
        end
    end

    // Entry flags, dispatch wins if the CDB names the slot being refilled
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entry_rdy[i]      <= 1'b0;
                entry_redirect[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (disp_accept && (tail_idx == rob_tag_t'(i))) begin
                    entry_rdy[i]      <= disp.rdy;
                    entry_redirect[i] <= 1'b0;
                end else if (cdb.en && (cdb.tag == rob_tag_t'(i))) begin
                    entry_rdy[i]      <= 1'b1;
                    entry_redirect[i] <= cdb.redirect;
                end
            end
        end
    end

    // Entry payload with the same dispatch over CDB priority
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (disp_accept && (tail_idx == rob_tag_t'(i))) begin
                entry_data[i]  <= disp.data;
                entry_rdest[i] <= disp.rdest;
            end else if (cdb.en && (cdb.tag == rob_tag_t'(i))) begin
                entry_target[i] <= cdb.addr;
                entry_data[i]   <= cdb.data;
            end
        end
    end

endmodule

// File: src/register_map.sv
/*
 * Architectural register map: committed values plus a busy bit and
 * the owning reorder buffer tag for every register
 */
module register_map import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  n_rst,
    retire_wr_if.sink             retire,
    regmap_lookup_if.responder    lookup,
    input  logic                  tag_wr_en,
    input  reg_addr_t             tag_wr_rdest,
    input  rob_tag_t              tag_wr_tag,
    input  logic                  flush
);

    data_t                values [REG_COUNT];
    logic [REG_COUNT-1:0] busy;
    rob_tag_t             owner  [REG_COUNT];

    // Committed values only change when an instruction retires
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                values[i] <= '0;
            end
        end else if (retire.en) begin
            values[retire.rdest] <= retire.data;
        end
    end

    // Busy marks track which registers still wait for an in-flight result
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy <= '0;
        end else if (flush) begin
            // Everything younger than the redirect is gone
            busy <= '0;
        end else begin
            // Only the newest owner may release the register
            if (retire.en && (owner[retire.rdest] == retire.tag)) begin
                busy[retire.rdest] <= 1'b0;
            end
            // A dispatch to the same register in this cycle takes it over again
            if (tag_wr_en) begin
                busy[tag_wr_rdest] <= 1'b1;
            end
        end
    end

    // Owner tag follows the most recent dispatch to each register
    always_ff @(posedge clk) begin
        if (tag_wr_en) begin
            owner[tag_wr_rdest] <= tag_wr_tag;
        end
    end

    // Lookups answer within the same cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup.data[i] = values[lookup.rsrc[i]];
            lookup.tag[i]  = owner[lookup.rsrc[i]];
            lookup.busy[i] = busy[lookup.rsrc[i]];
        end
    end

endmodule

// File: src/ooo_commit_top.sv
/*
 * Commit end of the out-of-order core: reorder buffer, pointers,
 * commit sequencer and register map behind plain ports
 */
module ooo_commit_top import rob_pkg::*; (
    input  logic      clk,
    input  logic      n_rst,
    // Dispatch side
    input  logic      disp_en,
    input  reg_addr_t disp_rdest,
    input  reg_addr_t disp_rsrc_a,
    input  reg_addr_t disp_rsrc_b,
    input  logic      disp_rdy,
    input  data_t     disp_data,
    output logic      disp_stall,
    output rob_tag_t  disp_tag,
    // Forwarded source operands for the instruction being dispatched
    output data_t     src_a_data,
    output rob_tag_t  src_a_tag,
    output logic      src_a_rdy,
    output data_t     src_b_data,
    output rob_tag_t  src_b_tag,
    output logic      src_b_rdy,
    // Common data bus
    input  logic      cdb_en,
    input  rob_tag_t  cdb_tag,
    input  data_t     cdb_data,
    input  logic      cdb_redirect,
    input  addr_t     cdb_addr,
    // Retire and redirect
    output logic      commit_en,
    output reg_addr_t commit_rdest,
    output data_t     commit_data,
    output logic      redirect,
    output addr_t     redirect_addr
);

    cdb_if           cdb ();
    rob_dispatch_if  disp ();
    regmap_lookup_if lookup ();
    retire_wr_if     retire ();

    rob_ptr_t      head;
    rob_ptr_t      tail;
    logic          full;
    logic          empty;
    logic          push;
    logic          pop;
    logic          flush;
    logic          tag_wr_en;
    reg_addr_t     tag_wr_rdest;
    rob_tag_t      tag_wr_tag;
    data_t         src_data [2];
    rob_tag_t      src_tag  [2];
    logic          src_rdy  [2];
    // Sequencer state, left visible for the bound assertions
    commit_state_t ctrl_state;

    assign cdb.en       = cdb_en;
    assign cdb.tag      = cdb_tag;
    assign cdb.data     = cdb_data;
    assign cdb.redirect = cdb_redirect;
    assign cdb.addr     = cdb_addr;

    assign disp.en    = disp_en;
    assign disp.rdest = disp_rdest;
    assign disp.rdy   = disp_rdy;
    assign disp.data  = disp_data;
    assign disp_stall = disp.stall;
    assign disp_tag   = disp.tag;

    assign src_a_data = src_data[0];
    assign src_a_tag  = src_tag[0];
    assign src_a_rdy  = src_rdy[0];
    assign src_b_data = src_data[1];
    assign src_b_tag  = src_tag[1];
    assign src_b_rdy  = src_rdy[1];

    assign commit_en    = retire.en;
    assign commit_rdest = retire.rdest;
    assign commit_data  = retire.data;

    // The retiring redirect empties the buffer at the same edge
    rob_pointers i_pointers (
        .clk   (clk),
        .n_rst (n_rst),
        .push  (push),
        .pop   (pop),
        .clear (redirect),
        .head  (head),
        .tail  (tail),
        .full  (full),
        .empty (empty)
    );

    commit_ctrl i_ctrl (
        .clk      (clk),
        .n_rst    (n_rst),
        .redirect (redirect),
        .flush    (flush),
        .state    (ctrl_state)
    );

    reorder_buffer i_rob (
        .clk           (clk),
        .n_rst         (n_rst),
        .cdb           (cdb.sink),
        .disp          (disp.sink),
        .rsrc_a        (disp_rsrc_a),
        .rsrc_b        (disp_rsrc_b),
        .flush         (flush),
        .head          (head),
        .tail          (tail),
        .full          (full),
        .empty         (empty),
        .lookup        (lookup.requester),
        .retire        (retire.source),
        .tag_wr_en     (tag_wr_en),
        .tag_wr_rdest  (tag_wr_rdest),
        .tag_wr_tag    (tag_wr_tag),
        .src_data      (src_data),
        .src_tag       (src_tag),
        .src_rdy       (src_rdy),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .push          (push),
        .pop           (pop)
    );

    register_map i_regmap (
        .clk          (clk),
        .n_rst        (n_rst),
        .retire       (retire.sink),
        .lookup       (lookup.responder),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_rdest (tag_wr_rdest),
        .tag_wr_tag   (tag_wr_tag),
        .flush        (flush)
    );

endmodule

// File: tb/ooo_commit_checker.sv
/*
 * Protocol assertions on the commit stage, bound into the top level
 */
module ooo_commit_checker import rob_pkg::*; (
    input logic          clk,
    input logic          n_rst,
    input logic          disp_en,
    input logic          disp_stall,
    input rob_tag_t      disp_tag,
    input logic          commit_en,
    input logic          redirect,
    input commit_state_t ctrl_state
);
    timeunit 1ns;
    timeprecision 100ps;

    // Nothing may retire in the cycle that wipes the busy marks
    no_commit_in_flush: assert property (
        @(posedge clk) disable iff (!n_rst)
        ((ctrl_state == FLUSH) && disp_stall) |-> !commit_en
    ) else $error("commit_en high during the flush cycle");

    // A retiring redirect closes dispatch for the following cycle
    stall_after_redirect: assert property (
        @(posedge clk) disable iff (!n_rst)
        redirect |=> disp_stall
    ) else $error("disp_stall low in the cycle after a redirect");

    // Tags are handed out in order, one per accepted instruction
    tag_steps_by_one: assert property (
        @(posedge clk) disable iff (!n_rst)
        (disp_en && !disp_stall && !redirect) |=>
            (disp_tag == ($past(disp_tag) + rob_tag_t'(1)))
    ) else $error("disp_tag did not advance by one after a dispatch");

endmodule

bind ooo_commit_top ooo_commit_checker i_checker (
    .clk        (clk),
    .n_rst      (n_rst),
    .disp_en    (disp_en),
    .disp_stall (disp_stall),
    .disp_tag   (disp_tag),
    .commit_en  (commit_en),
    .redirect   (redirect),
    .ctrl_state (ctrl_state)
);

// File: tb/tb_ooo_commit.sv
/*
 * Testbench for the commit stage: replays one cycle per pattern record
 * and compares the DUT outputs that the record selects for checking
 */
module tb_ooo_commit import rob_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam string PATTERN_FILE  = "tb/commit_patterns.txt";
    localparam int    READY_TIMEOUT = 20;
    localparam int    FIELD_COUNT   = 24;

    logic      clk;
    logic      n_rst;
    logic      disp_en, disp_rdy, disp_stall;
    reg_addr_t disp_rdest, disp_rsrc_a, disp_rsrc_b;
    data_t     disp_data;
    rob_tag_t  disp_tag, src_a_tag, src_b_tag;
    data_t     src_a_data, src_b_data;
    logic      src_a_rdy, src_b_rdy;
    logic      cdb_en, cdb_redirect;
    rob_tag_t  cdb_tag;
    data_t     cdb_data;
    addr_t     cdb_addr;
    logic      commit_en, redirect;
    reg_addr_t commit_rdest;
    data_t     commit_data;
    addr_t     redirect_addr;

    // Current record: repeat count, stimulus, check mask and expected values
    int         rep;
    logic       in_en, in_rdy, in_cen, in_credir;
    reg_addr_t  in_rdest, in_rsa, in_rsb;
    data_t      in_data, in_cdata;
    rob_tag_t   in_ctag;
    addr_t      in_caddr;
    logic [7:0] mask;
    logic       exp_stall, exp_commit, exp_redir, exp_ardy, exp_brdy;
    rob_tag_t   exp_tag;
    reg_addr_t  exp_rdest;
    data_t      exp_cdata, exp_adata, exp_bdata;
    addr_t      exp_raddr;

    // Expected owner tag per register, known once the patterns dispatch to it
    rob_tag_t tag_model [REG_COUNT];
    logic     tag_known [REG_COUNT];
    rob_tag_t next_tag;

    int errors;
    int checks;
    int line_no;

    ooo_commit_top i_dut (.*);

    // Free running clock with an 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: pattern line %0d, %s is %0h, expected %0h",
                     $time, line_no, what, got, want);
        end
    endtask

    // Dispatch has to open up within a bounded number of cycles after reset
    task automatic wait_dispatch_ready();
        int cycles;
        cycles = 0;
        while (disp_stall && (cycles < READY_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (disp_stall) begin
            $display("Timeout: dispatch still stalled %0d cycles after reset", READY_TIMEOUT);
            errors++;
        end
    endtask

    task automatic apply_record();
        disp_en      = in_en;
        disp_rdest   = in_rdest;
        disp_rsrc_a  = in_rsa;
        disp_rsrc_b  = in_rsb;
        disp_rdy     = in_rdy;
        disp_data    = in_data;
        cdb_en       = in_cen;
        cdb_tag      = in_ctag;
        cdb_data     = in_cdata;
        cdb_redirect = in_credir;
        cdb_addr     = in_caddr;
    endtask

    // Mask bits select stall, tag, commit, redirect, source A and source B
    // Data fields only count when the matching enable or rdy is expected high
    task automatic check_record();
        if (mask[0]) begin
            compare_value("disp_stall", 32'(disp_stall), 32'(exp_stall));
        end
        if (mask[1]) begin
            compare_value("disp_tag", 32'(disp_tag), 32'(exp_tag));
        end
        if (mask[2]) begin
            compare_value("commit_en", 32'(commit_en), 32'(exp_commit));
            if (exp_commit) begin
                compare_value("commit_rdest", 32'(commit_rdest), 32'(exp_rdest));
                compare_value("commit_data", commit_data, exp_cdata);
            end
        end
        if (mask[3]) begin
            compare_value("redirect", 32'(redirect), 32'(exp_redir));
            if (exp_redir) begin
                compare_value("redirect_addr", redirect_addr, exp_raddr);
            end
        end
        if (mask[4]) begin
            compare_value("src_a_rdy", 32'(src_a_rdy), 32'(exp_ardy));
            if (exp_ardy) begin
                compare_value("src_a_data", src_a_data, exp_adata);
            end
            if (tag_known[in_rsa]) begin
                compare_value("src_a_tag", 32'(src_a_tag), 32'(tag_model[in_rsa]));
            end
        end
        if (mask[5]) begin
            compare_value("src_b_rdy", 32'(src_b_rdy), 32'(exp_brdy));
            if (exp_brdy) begin
                compare_value("src_b_data", src_b_data, exp_bdata);
            end
            if (tag_known[in_rsb]) begin
                compare_value("src_b_tag", 32'(src_b_tag), 32'(tag_model[in_rsb]));
            end
        end
    endtask

    // Tags follow the tail, one per accepted dispatch, and restart at zero
    // once a redirect empties the buffer
    task automatic track_dispatch();
        if (in_en && mask[0] && !exp_stall) begin
            tag_model[in_rdest] = next_tag;
            tag_known[in_rdest] = 1'b1;
            next_tag++;
        end
        if (mask[3] && exp_redir) begin
            next_tag = '0;
        end
    endtask

    task automatic run_patterns();
        int    fd;
        int    fields;
        string line;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Comment and blank lines carry no cycle
            if ((line.len() < 2) || (line[0] == "#")) begin
                continue;
            end
            fields = $sscanf(line,
                "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                rep, in_en, in_rdest, in_rsa, in_rsb, in_rdy, in_data,
                in_cen, in_ctag, in_cdata, in_credir, in_caddr, mask,
                exp_stall, exp_tag, exp_commit, exp_rdest, exp_cdata,
                exp_redir, exp_raddr, exp_ardy, exp_adata, exp_brdy, exp_bdata);
            if (fields != FIELD_COUNT) begin
                $display("Pattern line %0d has %0d fields instead of %0d",
                         line_no, fields, FIELD_COUNT);
                errors++;
                continue;
            end
            for (int k = 0; k < rep; k++) begin
                @(posedge clk);
                #1;
                apply_record();
                // Combinational outputs have long settled by the falling edge
                @(negedge clk);
                check_record();
                track_dispatch();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        line_no  = 0;
        next_tag = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            tag_known[r] = 1'b0;
            tag_model[r] = '0;
        end
        // All DUT inputs start idle while reset is held
        n_rst        = 1'b0;
        disp_en      = 1'b0;
        disp_rdest   = '0;
        disp_rsrc_a  = '0;
        disp_rsrc_b  = '0;
        disp_rdy     = 1'b0;
        disp_data    = '0;
        cdb_en       = 1'b0;
        cdb_tag      = '0;
        cdb_data     = '0;
        cdb_redirect = 1'b0;
        cdb_addr     = '0;
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        wait_dispatch_ready();
        if (errors == 0) begin
            run_patterns();
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/commit_patterns.txt
# rep en rd rsa rsb rdy data | cdb: en tag data redir addr | mask, then expected values of
# stall tag commit rd data redirect addr a_rdy a_data b_rdy b_data (rep decimal, rest hex)
# Reset state
 1 0 00 00 00 0 00 0 0 00 0 0000 3f 0 0 0 00 00 0 0000 1 00 1 00
# Five dispatches, completed in reverse order, committed in order
 1 1 01 00 00 0 00 0 0 00 0 0000 0f 0 0 0 00 00 0 0000 0 00 0 00
 1 1 02 00 00 0 00 0 0 00 0 0000 0f 0 1 0 00 00 0 0000 0 00 0 00
 1 1 03 00 00 0 00 0 0 00 0 0000 0f 0 2 0 00 00 0 0000 0 00 0 00
 1 1 04 00 00 0 00 0 0 00 0 0000 0f 0 3 0 00 00 0 0000 0 00 0 00
 1 1 05 00 00 0 00 0 0 00 0 0000 0f 0 4 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 4 a5 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 3 a4 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 2 a3 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 1 a2 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 0 a1 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 01 a1 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 02 a2 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 03 a3 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 04 a4 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 05 a5 0 0000 0 00 0 00
# Source forwarding from the map, the CDB and ready entries
 1 1 08 01 02 0 00 0 0 00 0 0000 3f 0 5 0 00 00 0 0000 1 a1 1 a2
 1 1 09 00 00 1 c9 0 0 00 0 0000 07 0 6 0 00 00 0 0000 0 00 0 00
 1 1 0a 08 09 0 00 1 5 c8 0 0000 37 0 7 0 00 00 0 0000 1 c8 1 c9
 1 0 00 09 0a 0 00 1 7 ca 0 0000 34 0 0 1 08 c8 0 0000 1 c9 1 ca
 1 0 00 08 00 0 00 0 0 00 0 0000 14 0 0 1 09 c9 0 0000 1 c8 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 04 0 0 1 0a ca 0 0000 0 00 0 00
# Sixteen unfinished dispatches fill the buffer, one commit reopens it
16 1 06 00 00 0 00 0 0 00 0 0000 05 0 0 0 00 00 0 0000 0 00 0 00
 1 1 07 00 00 0 00 0 0 00 0 0000 07 1 8 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 8 b0 0 0000 07 1 8 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 05 1 0 1 06 b0 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 07 0 8 0 00 00 0 0000 0 00 0 00
# Redirect at the head discards the younger entries and restarts the tags
 1 0 00 00 00 0 00 1 a d1 0 0000 07 0 8 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 1 9 d0 1 1234 05 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 0d 0 0 1 06 d0 1 1234 0 00 0 00
 1 1 0b 00 00 0 00 0 0 00 0 0000 0f 1 0 0 00 00 0 0000 0 00 0 00
 1 0 00 06 08 0 00 0 0 00 0 0000 3f 0 0 0 00 00 0 0000 1 d0 1 c8
 1 1 0c 00 00 1 e0 0 0 00 0 0000 07 0 0 0 00 00 0 0000 0 00 0 00
 1 0 00 00 00 0 00 0 0 00 0 0000 07 0 1 1 0c e0 0 0000 0 00 0 00

// File: src.f
src/rob_pkg.sv
src/ooo_ifs.sv
src/rob_pointers.sv
src/commit_ctrl.sv
src/reorder_buffer.sv
src/register_map.sv
src/ooo_commit_top.sv
tb/ooo_commit_checker.sv
tb/tb_ooo_commit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the commit stage testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ooo_commit -f src.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
echo "Simulation finished without reported errors"
